// ==== verilog/tracker_consts.svh ====
`ifndef TRACKER_CONSTS_SVH
`define TRACKER_CONSTS_SVH

// pixel coordinates as produced by a 1280x720 raster
`define HCOUNT_W 11
`define VCOUNT_W 10

// one color channel after widening to 8 bits
`define CHAN_W 8

// packed rgb 5:6:5 word
`define RAW_PIXEL_W 16

// per-frame coordinate sums
`define SUM_W 32

// hit count, big enough for every pixel of a 1280x720 frame
`define COUNT_W 21

// restoring divider makes one quotient bit per cycle
`define DIV_STEPS `SUM_W

`endif

// ==== verilog/tracker_pkg.sv ====
package tracker_pkg;

  `include "tracker_consts.svh"

  typedef logic [`HCOUNT_W-1:0] hcount_t;
  typedef logic [`VCOUNT_W-1:0] vcount_t;
  typedef logic [`CHAN_W-1:0] chan_t;
  typedef logic [`RAW_PIXEL_W-1:0] raw_pixel_t;
  // red in the top byte, blue in the bottom byte
  typedef logic [3*`CHAN_W-1:0] rgb_t;
  typedef logic [`SUM_W-1:0] sum_t;
  typedef logic [`COUNT_W-1:0] count_t;

  // same code points as the switch decode of the camera board
  typedef enum logic [1:0] {
    CH_GREEN = 2'b00,
    CH_RED   = 2'b01,
    CH_BLUE  = 2'b10,
    CH_NONE  = 2'b11
  } channel_sel_t;

  // off is the spare code and shows black
  typedef enum logic [1:0] {
    VIEW_CAMERA    = 2'b00,
    VIEW_MASK      = 2'b01,
    VIEW_CROSSHAIR = 2'b10,
    VIEW_OFF       = 2'b11
  } view_sel_t;

  typedef enum logic [1:0] {
    DIV_IDLE = 2'b00,
    DIV_RUN  = 2'b01,
    DIV_DONE = 2'b10
  } div_state_t;

endpackage

// ==== verilog/mask_stream_if.sv ====
`timescale 1ns/1ps

// registered pixel stream out of the thresholder
interface mask_stream_if
  import tracker_pkg::*;
  (
  input logic clk_pixel
  );

  // pixel strobe, one per accepted input pixel
  logic valid;
  hcount_t hcount;
  vcount_t vcount;
  // widened 8:8:8 camera pixel
  rgb_t rgb;
  // mask bit, only meaningful with valid
  logic hit;
  // one cycle marker right after the last pixel of a frame
  logic frame_end;

  modport source (
    output valid, hcount, vcount, rgb, hit, frame_end
  );

  modport sink (
    input valid, hcount, vcount, rgb, hit, frame_end
  );

  // a frame end is a single pulse, never two frames back to back
  frame_end_is_pulse: assert property (@(posedge clk_pixel) frame_end |=> !frame_end)
    else $error("mask stream frame_end held for more than one cycle");

endinterface

// ==== verilog/channel_threshold.sv ====
`timescale 1ns/1ps

module channel_threshold
  import tracker_pkg::*;
  (
  input logic clk_pixel,
  input logic recent_reset,
  input logic pixel_valid_i,
  input hcount_t hcount_i,
  input vcount_t vcount_i,
  input raw_pixel_t pixel_i,
  input logic frame_end_i,
  input channel_sel_t channel_sel_i,
  input chan_t lower_i,
  input chan_t upper_i,
  mask_stream_if.source stream_o
  );

  rgb_t wide_rgb;
  chan_t sel_chan;
  logic in_range;

  // 5:6:5 to 8:8:8, low bits padded with zeros
  always_comb begin
    wide_rgb = {pixel_i[15:11], 3'b000, pixel_i[10:5], 2'b00, pixel_i[4:0], 3'b000};
  end

  // pick the channel that drives the mask
  always_comb begin
    case (channel_sel_i)
      CH_RED: sel_chan = wide_rgb[23:16];
      CH_GREEN: sel_chan = wide_rgb[15:8];
      CH_BLUE: sel_chan = wide_rgb[7:0];
      // none selects a zero channel
      default: sel_chan = '0;
    endcase
  end

  // both bounds inclusive
  always_comb begin
    in_range = (sel_chan >= lower_i) && (sel_chan <= upper_i);
  end

  // strobes of the stream
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      stream_o.valid <= 1'b0;
      stream_o.frame_end <= 1'b0;
    end else begin
      stream_o.valid <= pixel_valid_i;
      stream_o.frame_end <= frame_end_i;
    end
  end

  // pixel payload only moves with the input strobe
  always_ff @(posedge clk_pixel) begin
    if (pixel_valid_i) begin
      stream_o.hcount <= hcount_i;
      stream_o.vcount <= vcount_i;
      stream_o.rgb <= wide_rgb;
      stream_o.hit <= in_range;
    end
  end

endmodule

// ==== verilog/serial_divider.sv ====
`timescale 1ns/1ps
`include "tracker_consts.svh"

module serial_divider
  import tracker_pkg::*;
  (
  input logic clk_pixel,
  input logic recent_reset,
  input logic start_i,
  input sum_t dividend_i,
  input count_t divisor_i,
  output sum_t quotient_o,
  output logic done_o
  );

  localparam int STEP_W = $clog2(`DIV_STEPS);
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`DIV_STEPS - 1);

  div_state_t state_q;
  logic [STEP_W-1:0] step_q;
  // dividend shifts out the top while quotient bits shift in below
  sum_t quot_q;
  // partial remainder stays below the divisor
  logic [`COUNT_W-1:0] rem_q;
  count_t divisor_q;
  logic [`COUNT_W:0] trial;
  logic [`COUNT_W:0] diff;
  logic fits;

  // one restoring step
  always_comb begin
    trial = {rem_q, quot_q[`SUM_W-1]};
    fits = (trial >= {1'b0, divisor_q});
    diff = trial - {1'b0, divisor_q};
  end

  // idle or done accept a start, run lasts DIV_STEPS cycles
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      state_q <= DIV_IDLE;
    end else begin
      case (state_q)
        DIV_IDLE, DIV_DONE: begin
          state_q <= start_i ? DIV_RUN : DIV_IDLE;
        end
        DIV_RUN: begin
          if (step_q == LAST_STEP) begin
            state_q <= DIV_DONE;
          end
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (start_i && (state_q != DIV_RUN)) begin
      quot_q <= dividend_i;
      rem_q <= '0;
      divisor_q <= divisor_i;
      step_q <= '0;
    end else if (state_q == DIV_RUN) begin
      quot_q <= {quot_q[`SUM_W-2:0], fits};
      // top bit is zero either way, remainder < divisor
      rem_q <= fits ? diff[`COUNT_W-1:0] : trial[`COUNT_W-1:0];
      step_q <= step_q + 1'b1;
    end
  end

  // quotient is complete once all steps ran, and held after
  assign quotient_o = quot_q;
  assign done_o = (state_q == DIV_DONE);

  no_start_while_running: assert property (
    @(posedge clk_pixel) disable iff (recent_reset) start_i |-> state_q != DIV_RUN)
    else $error("divider started while a division was running");

  nonzero_divisor: assert property (
    @(posedge clk_pixel) disable iff (recent_reset) start_i |-> divisor_i != '0)
    else $error("divider started with a zero divisor");

endmodule

// ==== verilog/centroid_accum.sv ====
`timescale 1ns/1ps
`include "tracker_consts.svh"

module centroid_accum
  import tracker_pkg::*;
  (
  input logic clk_pixel,
  input logic recent_reset,
  mask_stream_if.sink stream_i,
  output hcount_t com_x_o,
  output vcount_t com_y_o,
  output logic com_valid_o
  );

  sum_t x_sum_q;
  sum_t y_sum_q;
  count_t hits_q;
  logic take;
  sum_t x_total;
  sum_t y_total;
  count_t hits_total;
  logic div_start;
  sum_t quot_x;
  sum_t quot_y;
  logic done_x;
  logic done_y;
  // set from start to done, covers both dividers
  logic div_busy_q;

  // running totals, including the pixel on the stream right now
  always_comb begin
    take = stream_i.valid && stream_i.hit;
    x_total = x_sum_q + (take ? sum_t'(stream_i.hcount) : '0);
    y_total = y_sum_q + (take ? sum_t'(stream_i.vcount) : '0);
    hits_total = hits_q + count_t'(take);
    // empty frames keep the old center
    div_start = stream_i.frame_end && (hits_total != '0);
  end

  // sums restart at every frame end, the totals went to the dividers
  always_ff @(posedge clk_pixel) begin
    if (recent_reset || stream_i.frame_end) begin
      x_sum_q <= '0;
      y_sum_q <= '0;
      hits_q <= '0;
    end else begin
      x_sum_q <= x_total;
      y_sum_q <= y_total;
      hits_q <= hits_total;
    end
  end

  serial_divider div_x_inst (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .start_i(div_start),
    .dividend_i(x_total),
    .divisor_i(hits_total),
    .quotient_o(quot_x),
    .done_o(done_x)
  );

  serial_divider div_y_inst (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .start_i(div_start),
    .dividend_i(y_total),
    .divisor_i(hits_total),
    .quotient_o(quot_y),
    .done_o(done_y)
  );

  // the mean of in-range coordinates always fits the coordinate width
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      com_x_o <= '0;
      com_y_o <= '0;
      com_valid_o <= 1'b0;
      div_busy_q <= 1'b0;
    end else begin
      com_valid_o <= done_x && done_y;
      if (done_x && done_y) begin
        com_x_o <= quot_x[`HCOUNT_W-1:0];
        com_y_o <= quot_y[`VCOUNT_W-1:0];
      end
      if (div_start) begin
        div_busy_q <= 1'b1;
      end else if (done_x && done_y) begin
        div_busy_q <= 1'b0;
      end
    end
  end

  // one frame accumulating and one dividing, never a third
  frame_end_spacing: assert property (
    @(posedge clk_pixel) disable iff (recent_reset) stream_i.frame_end |-> !div_busy_q)
    else $error("frame end arrived while the centroid division was busy");

endmodule

// ==== verilog/view_mux.sv ====
`timescale 1ns/1ps

module view_mux
  import tracker_pkg::*;
  (
  input logic clk_pixel,
  input logic recent_reset,
  mask_stream_if.sink stream_i,
  input hcount_t com_x_i,
  input vcount_t com_y_i,
  input view_sel_t view_sel_i,
  output logic pix_valid_o,
  output rgb_t pix_o
  );

  logic on_cross;
  rgb_t next_pix;

  // white row and column through the held center
  always_comb begin
    on_cross = (stream_i.hcount == com_x_i) || (stream_i.vcount == com_y_i);
    case (view_sel_i)
      VIEW_CAMERA: next_pix = stream_i.rgb;
      VIEW_MASK: next_pix = stream_i.hit ? '1 : '0;
      VIEW_CROSSHAIR: next_pix = on_cross ? '1 : stream_i.rgb;
      // off shows black
      default: next_pix = '0;
    endcase
  end

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= stream_i.valid;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (stream_i.valid) begin
      pix_o <= next_pix;
    end
  end

endmodule

// ==== verilog/color_tracker.sv ====
`timescale 1ns/1ps

module color_tracker
  import tracker_pkg::*;
  (
  input logic clk_pixel,
  input logic recent_reset,
  input logic pixel_valid_i,
  input hcount_t hcount_i,
  input vcount_t vcount_i,
  input raw_pixel_t pixel_i,
  input logic frame_end_i,
  input channel_sel_t channel_sel_i,
  input chan_t lower_i,
  input chan_t upper_i,
  input view_sel_t view_sel_i,
  output logic pix_valid_o,
  output rgb_t pix_o,
  output hcount_t com_x_o,
  output vcount_t com_y_o,
  output logic com_valid_o
  );

  // thresholded stream, fans out to the centroid and the output view
  mask_stream_if stream_if (.clk_pixel(clk_pixel));

  channel_threshold channel_threshold_inst (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .pixel_valid_i(pixel_valid_i),
    .hcount_i(hcount_i),
    .vcount_i(vcount_i),
    .pixel_i(pixel_i),
    .frame_end_i(frame_end_i),
    .channel_sel_i(channel_sel_i),
    .lower_i(lower_i),
    .upper_i(upper_i),
    .stream_o(stream_if.source)
  );

  centroid_accum centroid_accum_inst (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .stream_i(stream_if.sink),
    .com_x_o(com_x_o),
    .com_y_o(com_y_o),
    .com_valid_o(com_valid_o)
  );

  // crosshair uses the center held from the previous frame
  view_mux view_mux_inst (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .stream_i(stream_if.sink),
    .com_x_i(com_x_o),
    .com_y_i(com_y_o),
    .view_sel_i(view_sel_i),
    .pix_valid_o(pix_valid_o),
    .pix_o(pix_o)
  );

endmodule

// ==== sim/tb_color_tracker.sv ====
`timescale 1ns/1ps

module tb_color_tracker
  import tracker_pkg::*;
  ();

  // 64x32 frames with a short horizontal blanking gap
  localparam int H_PIX = 64;
  localparam int V_LINES = 32;
  localparam int H_BLANK = 8;
  // idle cycles after frame_end, longer than one division
  localparam int GAP = 40;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_FRAMES = 10;
  localparam int FRAME_CYCLES = V_LINES * (H_PIX + H_BLANK) + 1 + GAP;
  // twice the length of all frames and gaps
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES);

  logic clk_pixel = 1'b0;
  logic recent_reset;
  logic pixel_valid_i;
  hcount_t hcount_i;
  vcount_t vcount_i;
  raw_pixel_t pixel_i;
  logic frame_end_i;
  channel_sel_t channel_sel_i;
  chan_t lower_i;
  chan_t upper_i;
  view_sel_t view_sel_i;
  logic pix_valid_o;
  rgb_t pix_o;
  hcount_t com_x_o;
  vcount_t com_y_o;
  logic com_valid_o;

  integer seed = 49219;
  int cycle_count = 0;
  int error_count = 0;
  int check_count = 0;
  int pulse_count = 0;
  // expected pixels and the cycle each input went in
  rgb_t exp_pix_q[$];
  int exp_cycle_q[$];
  // model of the held center of mass
  hcount_t model_x = '0;
  vcount_t model_y = '0;
  // per-frame sums of the model
  int unsigned x_sum;
  int unsigned y_sum;
  int unsigned hit_count;
  channel_sel_t mask_sels [4] = '{CH_RED, CH_GREEN, CH_BLUE, CH_NONE};
  chan_t lo;
  chan_t hi;

  always #20 clk_pixel = ~clk_pixel;

  color_tracker color_tracker_inst (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .pixel_valid_i(pixel_valid_i),
    .hcount_i(hcount_i),
    .vcount_i(vcount_i),
    .pixel_i(pixel_i),
    .frame_end_i(frame_end_i),
    .channel_sel_i(channel_sel_i),
    .lower_i(lower_i),
    .upper_i(upper_i),
    .view_sel_i(view_sel_i),
    .pix_valid_o(pix_valid_o),
    .pix_o(pix_o),
    .com_x_o(com_x_o),
    .com_y_o(com_y_o),
    .com_valid_o(com_valid_o)
  );

  // 5:6:5 fields shifted up into 8-bit channels
  function automatic rgb_t widen_pixel(raw_pixel_t raw);
    chan_t r;
    chan_t g;
    chan_t b;
    r = chan_t'(raw[15:11]) << 3;
    g = chan_t'(raw[10:5]) << 2;
    b = chan_t'(raw[4:0]) << 3;
    return {r, g, b};
  endfunction

  function automatic logic is_hit(raw_pixel_t raw, channel_sel_t sel, chan_t lo_b, chan_t hi_b);
    rgb_t wide;
    chan_t c;
    wide = widen_pixel(raw);
    case (sel)
      CH_RED: c = wide[23:16];
      CH_GREEN: c = wide[15:8];
      CH_BLUE: c = wide[7:0];
      default: c = 8'h00;
    endcase
    return (c >= lo_b) && (c <= hi_b);
  endfunction

  // expected output pixel for one input pixel
  function automatic rgb_t expect_pixel(raw_pixel_t raw, hcount_t hc, vcount_t vc,
                                        channel_sel_t sel, chan_t lo_b, chan_t hi_b,
                                        view_sel_t view, hcount_t cx, vcount_t cy);
    case (view)
      VIEW_CAMERA: return widen_pixel(raw);
      VIEW_MASK: return is_hit(raw, sel, lo_b, hi_b) ? 24'hffffff : 24'h000000;
      VIEW_CROSSHAIR: return (hc == cx || vc == cy) ? 24'hffffff : widen_pixel(raw);
      default: return 24'h000000;
    endcase
  endfunction

  // expected center coordinate, floor of sum over count
  function automatic int unsigned floor_mean(int unsigned sum, int unsigned count);
    return sum / count;
  endfunction

  // four-state compare, an unknown value never passes
  task automatic check_equal(input logic [31:0] got, input logic [31:0] want,
                             input string what);
    check_count++;
    assert (got === want) else begin
      error_count++;
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  always @(posedge clk_pixel) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  // outputs are sampled mid-cycle, away from the clock edge
  always @(negedge clk_pixel) begin : compare_outputs
    rgb_t exp_pix;
    int exp_cycle;
    if (com_valid_o === 1'b1) begin
      pulse_count++;
    end
    if (pix_valid_o === 1'b1) begin
      if (exp_pix_q.size() == 0) begin
        error_count++;
        $display("output pixel at %0t came with no input pixel pending", $time);
      end else begin
        exp_pix = exp_pix_q.pop_front();
        exp_cycle = exp_cycle_q.pop_front();
        check_count++;
        assert (pix_o == exp_pix) else begin
          error_count++;
          $display("CHECK FAILED at %0t: pixel %h, expected %h", $time, pix_o, exp_pix);
        end
        check_equal(cycle_count - exp_cycle, 2, "pixel latency in cycles");
      end
    end
  end

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_pixel);
      #2;
      pixel_valid_i = 1'b0;
      frame_end_i = 1'b0;
    end
  endtask

  task automatic drive_pixel(input hcount_t hc, input vcount_t vc, input raw_pixel_t raw);
    @(posedge clk_pixel);
    #2;
    pixel_valid_i = 1'b1;
    frame_end_i = 1'b0;
    hcount_i = hc;
    vcount_i = vc;
    pixel_i = raw;
    exp_pix_q.push_back(expect_pixel(raw, hc, vc, channel_sel_i, lower_i, upper_i,
                                     view_sel_i, model_x, model_y));
    exp_cycle_q.push_back(cycle_count);
    if (is_hit(raw, channel_sel_i, lower_i, upper_i)) begin
      x_sum += hc;
      y_sum += vc;
      hit_count++;
    end
  endtask

  task automatic set_selects(input channel_sel_t sel, input chan_t lo_b, input chan_t hi_b,
                             input view_sel_t view);
    channel_sel_i = sel;
    lower_i = lo_b;
    upper_i = hi_b;
    view_sel_i = view;
  endtask

  // random bounds, lower never above upper
  task automatic pick_bounds(output chan_t lo_b, output chan_t hi_b);
    chan_t a;
    chan_t b;
    a = chan_t'($random(seed));
    b = chan_t'($random(seed));
    lo_b = (a < b) ? a : b;
    hi_b = (a < b) ? b : a;
  endtask

  // rect_mode puts full red on a 20x10 block and keeps red below full elsewhere
  task automatic run_frame(input logic rect_mode);
    raw_pixel_t raw;
    int pulses_before;
    x_sum = 0;
    y_sum = 0;
    hit_count = 0;
    // pulses from the start of the frame on, so a stray one mid-frame also counts
    pulses_before = pulse_count;
    for (int v = 0; v < V_LINES; v++) begin
      for (int h = 0; h < H_PIX; h++) begin
        raw = raw_pixel_t'($random(seed));
        if (rect_mode) begin
          if (h >= 10 && h < 30 && v >= 5 && v < 15) begin
            raw[15:11] = 5'h1f;
          end else if (raw[15:11] == 5'h1f) begin
            raw[15:11] = 5'h00;
          end
        end
        drive_pixel(hcount_t'(h), vcount_t'(v), raw);
      end
      idle_cycles(H_BLANK);
    end
    @(posedge clk_pixel);
    #2;
    frame_end_i = 1'b1;
    idle_cycles(GAP);
    // hits give exactly one new center, an empty frame keeps the old one
    if (hit_count != 0) begin
      model_x = hcount_t'(floor_mean(x_sum, hit_count));
      model_y = vcount_t'(floor_mean(y_sum, hit_count));
      check_equal(pulse_count - pulses_before, 1, "com_valid_o pulses");
    end else begin
      check_equal(pulse_count - pulses_before, 0, "com_valid_o pulses on empty frame");
    end
    check_equal(com_x_o, model_x, "com_x_o");
    check_equal(com_y_o, model_y, "com_y_o");
  endtask

  initial begin
    recent_reset = 1'b1;
    pixel_valid_i = 1'b0;
    hcount_i = '0;
    vcount_i = '0;
    pixel_i = '0;
    frame_end_i = 1'b0;
    set_selects(CH_RED, 8'h80, 8'hff, VIEW_CAMERA);
    repeat (RESET_CYCLES) @(posedge clk_pixel);
    #2;
    recent_reset = 1'b0;
    idle_cycles(4);
    // center starts at the origin with no output pixel
    check_equal(com_x_o, 0, "com_x_o after reset");
    check_equal(com_y_o, 0, "com_y_o after reset");
    check_equal(pix_valid_o, 0, "pix_valid_o after reset");
    check_equal(com_valid_o, 0, "com_valid_o after reset");
    check_equal(pulse_count, 0, "com_valid_o pulses after reset");
    // camera view
    run_frame(1'b0);
    // mask view with every channel, none with a zero lower bound
    foreach (mask_sels[i]) begin
      pick_bounds(lo, hi);
      if (mask_sels[i] == CH_NONE) begin
        lo = 8'h00;
      end
      set_selects(mask_sels[i], lo, hi, VIEW_MASK);
      run_frame(1'b0);
    end
    // known rectangle, centroid floors to (19, 9)
    set_selects(CH_RED, 8'hf8, 8'hff, VIEW_MASK);
    run_frame(1'b1);
    // random hits on green
    lo = chan_t'($random(seed)) & 8'h7f;
    set_selects(CH_GREEN, lo, lo + 8'h60, VIEW_CAMERA);
    run_frame(1'b0);
    // no hits at all, center must hold
    set_selects(CH_NONE, 8'h10, 8'hff, VIEW_MASK);
    run_frame(1'b0);
    pick_bounds(lo, hi);
    set_selects(CH_BLUE, lo, hi, VIEW_CROSSHAIR);
    run_frame(1'b0);
    set_selects(CH_BLUE, lo, hi, VIEW_OFF);
    run_frame(1'b0);
    idle_cycles(4);
    check_equal(exp_pix_q.size(), 0, "pixels still pending");
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/tracker_pkg.sv
verilog/mask_stream_if.sv
verilog/channel_threshold.sv
verilog/serial_divider.sv
verilog/centroid_accum.sv
verilog/view_mux.sv
verilog/color_tracker.sv
sim/tb_color_tracker.sv

// ==== Bender.yml ====
package:
  name: color_tracker

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/tracker_pkg.sv
      - verilog/mask_stream_if.sv
      - verilog/channel_threshold.sv
      - verilog/serial_divider.sv
      - verilog/centroid_accum.sv
      - verilog/view_mux.sv
      - verilog/color_tracker.sv
  - target: simulation
    files:
      - sim/tb_color_tracker.sv
